// ==== sim.f ====
icache_pkg.sv
icache_lookup_if.sv
icache_fill_if.sv
icache_line_store.sv
icache_hit_select.sv
icache_miss_unit.sv
icache_controller.sv
tb_icache_controller.sv

// ==== tb_icache_controller.sv ====
`timescale 1ns/1ps

module tb_icache_controller;

  // the whole sequence needs well under a hundred cycles
  localparam int MAX_CYCLES = 2000;

  logic                    clk = 1'b0;
  logic                    reset;
  logic                    fetch_req_i;
  icache_pkg::pc_t         pc_i;
  logic                    mmu_exception_i;
  icache_pkg::inst_t       inst_o [0:icache_pkg::FETCH_WIDTH-1];
  logic [icache_pkg::FETCH_WIDTH-1:0] inst_valid_o;
  logic                    ic_miss_o;
  icache_pkg::block_addr_t mem_req_addr_o;
  logic                    mem_req_valid_o;

  // response side belongs to the memory model
  icache_pkg::tag_t        mem_resp_tag_i   = '0;
  icache_pkg::index_t      mem_resp_index_i = '0;
  icache_pkg::line_t       mem_resp_data_i  = '0;
  logic                    mem_resp_valid_i = 1'b0;

  // memory model state
  int                      resp_wait    = 0;
  int                      retry_wait   = 0;
  int                      req_count    = 0;
  logic                    send_bad_tag = 1'b0;
  logic                    bad_pending  = 1'b0;
  icache_pkg::block_addr_t pend_addr    = '0;

  // bookkeeping
  int                      errors = 0;
  int                      test_start_errors = 0;
  int                      pass_count = 0;
  int                      fail_count = 0;
  int                      cycle_count = 0;
  integer                  seed = 32'he8f2;
  logic [13:0]             tag_a, tag_b, tag_c, tag_d, tag_e;
  icache_pkg::block_addr_t addr_a, addr_b, addr_c, addr_d;

  icache_controller i_icache_controller (
    .clk              (clk),
    .reset            (reset),
    .fetch_req_i      (fetch_req_i),
    .pc_i             (pc_i),
    .inst_o           (inst_o),
    .inst_valid_o     (inst_valid_o),
    .mmu_exception_i  (mmu_exception_i),
    .ic_miss_o        (ic_miss_o),
    .mem_req_addr_o   (mem_req_addr_o),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_resp_tag_i   (mem_resp_tag_i),
    .mem_resp_index_i (mem_resp_index_i),
    .mem_resp_data_i  (mem_resp_data_i),
    .mem_resp_valid_i (mem_resp_valid_i)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////////////////////////////////////////

  // pc kept below 2**24, so only 14 tag bits are ever set
  function automatic icache_pkg::pc_t make_pc(input logic [13:0] tag,
                                              input icache_pkg::index_t index,
                                              input icache_pkg::offset_t offset);
    return {8'b0, tag, index, offset, 3'b000};
  endfunction

  // stored word k of a line holds the slot number above the 26 bit block address
  function automatic icache_pkg::line_t model_line(input icache_pkg::block_addr_t addr);
    icache_pkg::line_t line;
    line = '0;
    for (int k = 0; k < icache_pkg::INSTS_IN_LINE; k++)
    begin
      line[k*icache_pkg::STORED_INST_BITS +: icache_pkg::STORED_INST_BITS] = {14'(k), addr};
    end
    return line;
  endfunction

  // a slot beyond the line end reads zero and the upper 24 bits stay zero
  function automatic icache_pkg::inst_t expected_inst(input icache_pkg::block_addr_t addr,
                                                      input int word);
    icache_pkg::inst_t inst;
    inst = '0;
    if (word < icache_pkg::INSTS_IN_LINE)
    begin
      inst[39:0] = {14'(word), addr};
    end
    return inst;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////////////////////

  // answers 3 cycles after a request
  // in bad tag mode a wrong tag comes first and the right response 3 cycles later
  always @(negedge clk)
  begin
    mem_resp_valid_i = 1'b0;
    if (mem_req_valid_o)
    begin
      req_count++;
      pend_addr   = mem_req_addr_o;
      bad_pending = send_bad_tag;
      resp_wait   = 3;
      retry_wait  = send_bad_tag ? 6 : 0;
    end
    else
    begin
      if (resp_wait > 0)
      begin
        resp_wait--;
        if (resp_wait == 0)
        begin
          mem_resp_valid_i = 1'b1;
          mem_resp_tag_i   = pend_addr[icache_pkg::INDEX_BITS +: icache_pkg::TAG_BITS] ^
                             {21'b0, bad_pending};
          mem_resp_index_i = pend_addr[icache_pkg::INDEX_BITS-1:0];
          mem_resp_data_i  = model_line(pend_addr);
        end
      end
      if (retry_wait > 0)
      begin
        retry_wait--;
        if (retry_wait == 0)
        begin
          mem_resp_valid_i = 1'b1;
          mem_resp_tag_i   = pend_addr[icache_pkg::INDEX_BITS +: icache_pkg::TAG_BITS];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // miss strobe to fetch mirrors the request strobe
  assert property (@(posedge clk) disable iff (reset) ic_miss_o == mem_req_valid_o)
  else
  begin
    $display("mismatch at %0t: ic_miss_o %b mem_req_valid_o %b", $time, ic_miss_o,
             mem_req_valid_o);
    errors++;
  end

  // a request is a one cycle pulse
  assert property (@(posedge clk) disable iff (reset) mem_req_valid_o |=> !mem_req_valid_o)
  else
  begin
    $display("request strobe held for more than one cycle at %0t", $time);
    errors++;
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp)
    else
    begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    if (errors == test_start_errors)
    begin
      pass_count++;
      $display("test %s: ok", name);
    end
    else
    begin
      fail_count++;
      $display("test %s: %0d errors", name, errors - test_start_errors);
    end
    test_start_errors = errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // drive on the falling edge and read outputs 5 ns later while clk is low
  task automatic drive_fetch(input logic req, input icache_pkg::pc_t pc, input logic mmu);
    @(negedge clk);
    fetch_req_i     = req;
    pc_i            = pc;
    mmu_exception_i = mmu;
    #5;
  endtask

  task automatic hold_cycle();
    @(negedge clk);
    #5;
  endtask

  // bounded wait for the model to answer
  task automatic wait_response(input string what);
    int n;
    n = 0;
    while (!mem_resp_valid_i && n < 10)
    begin
      hold_cycle();
      n++;
    end
    if (!mem_resp_valid_i)
    begin
      $display("no memory response seen for %s", what);
      errors++;
    end
  endtask

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial
  begin
    reset           = 1'b1;
    fetch_req_i     = 1'b0;
    pc_i            = '0;
    mmu_exception_i = 1'b0;
    tag_a  = 14'($random(seed));
    tag_b  = 14'($random(seed));
    tag_c  = 14'($random(seed));
    tag_d  = 14'($random(seed));
    tag_e  = 14'($random(seed));
    addr_a = {8'b0, tag_a, 4'd3};
    addr_b = {8'b0, tag_b, 4'd9};
    addr_c = {8'b0, tag_c, 4'd12};
    addr_d = {8'b0, tag_d, 4'd5};
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // cold miss with the request one cycle later
    drive_fetch(1'b1, make_pc(tag_a, 4'd3, 3'd2), 1'b0);
    check_value("inst_valid_o", inst_valid_o, 2'b00);
    check_value("mem_req_valid_o", mem_req_valid_o, 1'b0);
    hold_cycle();
    check_value("mem_req_valid_o", mem_req_valid_o, 1'b1);
    check_value("mem_req_addr_o", mem_req_addr_o, addr_a);
    check_value("ic_miss_o", ic_miss_o, 1'b1);
    finish_test("cold miss");

    // fetch stays on through the fill cycle and then hits
    wait_response("line a");
    hold_cycle();
    check_value("inst_valid_o", inst_valid_o, 2'b00);
    hold_cycle();
    check_value("inst_valid_o", inst_valid_o, 2'b11);
    check_value("inst_o[0]", inst_o[0], expected_inst(addr_a, 2));
    check_value("inst_o[1]", inst_o[1], expected_inst(addr_a, 3));
    check_value("request count", req_count, 1);
    finish_test("fill then hit");

    // last slot and the one before it
    drive_fetch(1'b1, make_pc(tag_a, 4'd3, 3'd7), 1'b0);
    check_value("inst_valid_o", inst_valid_o, 2'b01);
    check_value("inst_o[0]", inst_o[0], expected_inst(addr_a, 7));
    check_value("inst_o[1]", inst_o[1], 64'h0);
    drive_fetch(1'b1, make_pc(tag_a, 4'd3, 3'd6), 1'b0);
    check_value("inst_valid_o", inst_valid_o, 2'b11);
    check_value("inst_o[0]", inst_o[0], expected_inst(addr_a, 6));
    check_value("inst_o[1]", inst_o[1], expected_inst(addr_a, 7));
    finish_test("end of line");

    // second miss while b is outstanding gets no request
    drive_fetch(1'b1, make_pc(tag_b, 4'd9, 3'd0), 1'b0);
    drive_fetch(1'b0, make_pc(tag_b, 4'd9, 3'd0), 1'b0);
    check_value("mem_req_addr_o", mem_req_addr_o, addr_b);
    drive_fetch(1'b1, make_pc(tag_c, 4'd12, 3'd1), 1'b0);
    hold_cycle();
    check_value("mem_req_valid_o", mem_req_valid_o, 1'b0);
    check_value("request count", req_count, 2);
    // fetch of c keeps replaying, the fill of b re-arms its miss
    wait_response("line b");
    hold_cycle();
    hold_cycle();
    check_value("mem_req_valid_o", mem_req_valid_o, 1'b0);
    hold_cycle();
    check_value("mem_req_valid_o", mem_req_valid_o, 1'b1);
    check_value("mem_req_addr_o", mem_req_addr_o, addr_c);
    wait_response("line c");
    hold_cycle();
    hold_cycle();
    check_value("inst_valid_o", inst_valid_o, 2'b11);
    check_value("inst_o[0]", inst_o[0], expected_inst(addr_c, 1));
    check_value("request count", req_count, 3);
    finish_test("single mshr");

    // line d keeps missing after a wrong tag response
    send_bad_tag = 1'b1;
    drive_fetch(1'b1, make_pc(tag_d, 4'd5, 3'd4), 1'b0);
    hold_cycle();
    send_bad_tag = 1'b0;
    check_value("mem_req_addr_o", mem_req_addr_o, addr_d);
    wait_response("wrong tag");
    hold_cycle();
    hold_cycle();
    check_value("inst_valid_o", inst_valid_o, 2'b00);
    wait_response("line d");
    hold_cycle();
    hold_cycle();
    check_value("inst_valid_o", inst_valid_o, 2'b11);
    check_value("inst_o[1]", inst_o[1], expected_inst(addr_d, 5));
    check_value("request count", req_count, 4);
    finish_test("mismatched response");

    // forced hit on a line that was never filled
    drive_fetch(1'b1, make_pc(tag_e, 4'd14, 3'd0), 1'b1);
    check_value("inst_valid_o[0]", inst_valid_o[0], 1'b1);
    hold_cycle();
    check_value("mem_req_valid_o", mem_req_valid_o, 1'b0);
    drive_fetch(1'b0, '0, 1'b0);
    check_value("request count", req_count, 4);
    finish_test("mmu exception");

    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0 && errors == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== icache_controller.sv ====
`timescale 1ns/1ps

module icache_controller (
  input  logic                    clk,
  input  logic                    reset,

  // fetch side
  input  logic                    fetch_req_i,
  input  icache_pkg::pc_t         pc_i,
  output icache_pkg::inst_t       inst_o [0:icache_pkg::FETCH_WIDTH-1],
  output logic [icache_pkg::FETCH_WIDTH-1:0] inst_valid_o,
  input  logic                    mmu_exception_i,
  output logic                    ic_miss_o,

  // request to memory
  output icache_pkg::block_addr_t mem_req_addr_o,
  output logic                    mem_req_valid_o,

  // response from memory
  input  icache_pkg::tag_t        mem_resp_tag_i,
  input  icache_pkg::index_t      mem_resp_index_i,
  input  icache_pkg::line_t       mem_resp_data_i,
  input  logic                    mem_resp_valid_i
);

  ////////////////////////////////////////////////////////////////////////////
  // internal links
  ////////////////////////////////////////////////////////////////////////////

  // array read between the store and the hit logic
  icache_lookup_if lookup_bus ();

  // line write from the miss unit
  icache_fill_if   fill_bus ();

  // hit decision feeding the miss detection
  logic hit;

  ////////////////////////////////////////////////////////////////////////////
  // blocks
  ////////////////////////////////////////////////////////////////////////////

  icache_line_store i_line_store (
    .clk    (clk),
    .reset  (reset),
    .lookup (lookup_bus.store),
    .fill   (fill_bus.sink)
  );

  icache_hit_select i_hit_select (
    .pc_i            (pc_i),
    .fetch_req_i     (fetch_req_i),
    .mmu_exception_i (mmu_exception_i),
    .lookup          (lookup_bus.reader),
    .hit_o           (hit),
    .inst_o          (inst_o),
    .inst_valid_o    (inst_valid_o)
  );

  icache_miss_unit i_miss_unit (
    .clk              (clk),
    .reset            (reset),
    .fetch_req_i      (fetch_req_i),
    .pc_i             (pc_i),
    .hit_i            (hit),
    .mem_resp_tag_i   (mem_resp_tag_i),
    .mem_resp_index_i (mem_resp_index_i),
    .mem_resp_data_i  (mem_resp_data_i),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_req_addr_o   (mem_req_addr_o),
    .mem_req_valid_o  (mem_req_valid_o),
    .fill             (fill_bus.source)
  );

  // miss indication to fetch is the request strobe itself
  assign ic_miss_o = mem_req_valid_o;

endmodule

// ==== icache_miss_unit.sv ====
`timescale 1ns/1ps

module icache_miss_unit (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    fetch_req_i,
  input  icache_pkg::pc_t         pc_i,
  input  logic                    hit_i,
  input  icache_pkg::tag_t        mem_resp_tag_i,
  input  icache_pkg::index_t      mem_resp_index_i,
  input  icache_pkg::line_t       mem_resp_data_i,
  input  logic                    mem_resp_valid_i,
  output icache_pkg::block_addr_t mem_req_addr_o,
  output logic                    mem_req_valid_o,
  icache_fill_if.source           fill
);

  localparam int INDEX_LSB = icache_pkg::INST_BYTE_OFFSET_LOG + icache_pkg::OFFSET_BITS;
  localparam int TAG_LSB   = INDEX_LSB + icache_pkg::INDEX_BITS;

  ////////////////////////////////////////////////////////////////////////////
  // registered pc
  ////////////////////////////////////////////////////////////////////////////

  icache_pkg::tag_t   pc_tag_reg;
  icache_pkg::index_t pc_index_reg;

  // address of last cycle's fetch, lines up with the miss flag
  always_ff @(posedge clk)
  begin
    pc_tag_reg   <= pc_i[TAG_LSB +: icache_pkg::TAG_BITS];
    pc_index_reg <= pc_i[INDEX_LSB +: icache_pkg::INDEX_BITS];
  end

  ////////////////////////////////////////////////////////////////////////////
  // miss pulse
  ////////////////////////////////////////////////////////////////////////////

  logic miss_d1;
  logic miss_d2;
  logic miss_pulse;
  logic mshr_valid;
  icache_pkg::tag_t   mshr_tag;
  icache_pkg::index_t mshr_index;

  // a fill drops both flags so a fetch still missing makes a fresh pulse
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      miss_d1 <= 1'b0;
      miss_d2 <= 1'b0;
    end
    else
    begin
      miss_d1 <= fetch_req_i & ~hit_i & ~fill.fill_valid;
      miss_d2 <= miss_d1 & ~fill.fill_valid;
    end
  end

  // rising edge only, a miss held over many cycles asks once
  assign miss_pulse = miss_d1 & ~miss_d2;

  // request only when the mshr is free or is being freed this cycle
  // otherwise fetch replays and the miss is dropped
  assign mem_req_valid_o = miss_pulse & (~mshr_valid | fill.fill_valid);
  assign mem_req_addr_o  = {pc_tag_reg, pc_index_reg};

  ////////////////////////////////////////////////////////////////////////////
  // mshr
  ////////////////////////////////////////////////////////////////////////////

  // set by a request, cleared by a fill
  // request and fill together keep it busy with the new address
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      mshr_valid <= 1'b0;
    end
    else
    begin
      if (mem_req_valid_o)
      begin
        mshr_valid <= 1'b1;
      end
      else if (fill.fill_valid)
      begin
        mshr_valid <= 1'b0;
      end
    end
  end

  // outstanding block address, loaded with each request
  always_ff @(posedge clk)
  begin
    if (mem_req_valid_o)
    begin
      mshr_tag   <= pc_tag_reg;
      mshr_index <= pc_index_reg;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // fill capture
  ////////////////////////////////////////////////////////////////////////////

  // only the response for the outstanding block is taken, others are dropped
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      fill.fill_valid <= 1'b0;
    end
    else
    begin
      fill.fill_valid <= mem_resp_valid_i & mshr_valid &
                         (mem_resp_tag_i == mshr_tag) &
                         (mem_resp_index_i == mshr_index);
    end
  end

  // line and its address wait one cycle next to fill_valid
  always_ff @(posedge clk)
  begin
    fill.fill_index <= mshr_index;
    fill.fill_tag   <= mshr_tag;
    fill.fill_data  <= mem_resp_data_i;
  end

endmodule

// ==== icache_hit_select.sv ====
`timescale 1ns/1ps

module icache_hit_select (
  input  icache_pkg::pc_t   pc_i,
  input  logic              fetch_req_i,
  input  logic              mmu_exception_i,
  icache_lookup_if.reader   lookup,
  output logic              hit_o,
  output icache_pkg::inst_t inst_o [0:icache_pkg::FETCH_WIDTH-1],
  output logic [icache_pkg::FETCH_WIDTH-1:0] inst_valid_o
);

  // bit positions of the pc fields
  // tag above index above offset above the ignored byte bits
  localparam int OFFSET_LSB = icache_pkg::INST_BYTE_OFFSET_LOG;
  localparam int INDEX_LSB  = OFFSET_LSB + icache_pkg::OFFSET_BITS;
  localparam int TAG_LSB    = INDEX_LSB + icache_pkg::INDEX_BITS;

  // zero bits added above each stored instruction
  localparam int PAD_BITS   = icache_pkg::INST_BITS - icache_pkg::STORED_INST_BITS;

  ////////////////////////////////////////////////////////////////////////////
  // pc split
  ////////////////////////////////////////////////////////////////////////////

  icache_pkg::offset_t pc_offset;
  icache_pkg::index_t  pc_index;
  icache_pkg::tag_t    pc_tag;
  logic                hit;

  assign pc_offset = pc_i[OFFSET_LSB +: icache_pkg::OFFSET_BITS];
  assign pc_index  = pc_i[INDEX_LSB +: icache_pkg::INDEX_BITS];
  assign pc_tag    = pc_i[TAG_LSB +: icache_pkg::TAG_BITS];

  // unregistered index goes straight to the array read
  assign lookup.index = pc_index;

  ////////////////////////////////////////////////////////////////////////////
  // hit
  ////////////////////////////////////////////////////////////////////////////

  // a real hit needs a request, a tag match and a valid line
  // an mmu exception forces a hit so that no line is requested for a bad pc
  // whatever the array holds is then passed on, the exception is dealt with
  // further down the pipe
  assign hit = (fetch_req_i & lookup.valid & (lookup.tag == pc_tag)) | mmu_exception_i;

  assign hit_o = hit;

  ////////////////////////////////////////////////////////////////////////////
  // slot select
  ////////////////////////////////////////////////////////////////////////////

  // slot k reads word offset+k of the line
  // past the end of the line the slot is invalid and reads zero
  always_comb
  begin
    int                                        slot;
    logic [icache_pkg::STORED_INST_BITS-1:0]   word;
    for (int k = 0; k < icache_pkg::FETCH_WIDTH; k++)
    begin
      slot = int'(pc_offset) + k;
      word = '0;
      if (slot < icache_pkg::INSTS_IN_LINE)
      begin
        word = lookup.line[slot*icache_pkg::STORED_INST_BITS +: icache_pkg::STORED_INST_BITS];
      end
      // widen to pipeline width
      inst_o[k] = {{PAD_BITS{1'b0}}, word};

      // slot 0 always qualifies since offset never reaches the line size
      inst_valid_o[k] = hit & (slot < icache_pkg::INSTS_IN_LINE);
    end
  end

endmodule

// ==== icache_line_store.sv ====
`timescale 1ns/1ps

module icache_line_store (
  input  logic            clk,
  input  logic            reset,
  icache_lookup_if.store  lookup,
  icache_fill_if.sink     fill
);

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  // one full line of packed 40 bit instructions per entry
  icache_pkg::line_t                  data_array [icache_pkg::NUM_LINES];

  // one tag per line
  icache_pkg::tag_t                   tag_array  [icache_pkg::NUM_LINES];

  // one valid bit per line, the only state that comes out of reset
  logic [icache_pkg::NUM_LINES-1:0]   valid_array;

  ////////////////////////////////////////////////////////////////////////////
  // lookup read
  ////////////////////////////////////////////////////////////////////////////

  // asynchronous read at the fetch index
  // hit logic sees the entry in the same cycle as the pc
  assign lookup.line  = data_array[lookup.index];
  assign lookup.tag   = tag_array[lookup.index];
  assign lookup.valid = valid_array[lookup.index];

  ////////////////////////////////////////////////////////////////////////////
  // fill write
  ////////////////////////////////////////////////////////////////////////////

  // data and tag are written together at the end of the fill cycle
  always_ff @(posedge clk)
  begin
    if (fill.fill_valid)
    begin
      data_array[fill.fill_index] <= fill.fill_data;
      tag_array[fill.fill_index]  <= fill.fill_tag;
    end
  end

  // valid bits start cleared, a fill marks its line usable
  // lines are never invalidated apart from reset
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      valid_array <= '0;
    end
    else
    begin
      if (fill.fill_valid)
      begin
        valid_array[fill.fill_index] <= 1'b1;
      end
    end
  end

endmodule

// ==== icache_fill_if.sv ====
`timescale 1ns/1ps

// line write from the miss handling logic into the arrays
interface icache_fill_if;

  // high for one cycle per accepted memory response
  logic               fill_valid;

  // where the line goes and what it is tagged with
  icache_pkg::index_t fill_index;
  icache_pkg::tag_t   fill_tag;
  icache_pkg::line_t  fill_data;

  // miss unit side
  modport source (
    output fill_valid,
    output fill_index,
    output fill_tag,
    output fill_data
  );

  // array side
  modport sink (
    input  fill_valid,
    input  fill_index,
    input  fill_tag,
    input  fill_data
  );

endinterface

// ==== icache_lookup_if.sv ====
`timescale 1ns/1ps

// read path between the hit selector and the arrays
interface icache_lookup_if;

  // index taken from the current fetch pc
  icache_pkg::index_t index;

  // entry at that index, returned combinationally
  icache_pkg::tag_t   tag;
  logic               valid;
  icache_pkg::line_t  line;

  // array side
  modport store (
    input  index,
    output tag,
    output valid,
    output line
  );

  // lookup side
  modport reader (
    output index,
    input  tag,
    input  valid,
    input  line
  );

endinterface

// ==== icache_pkg.sv ====
package icache_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // cache geometry
  ////////////////////////////////////////////////////////////////////////////

  // fetch pc width
  localparam int PC_BITS              = 32;

  // low pc bits select a byte inside one instruction and are ignored here
  localparam int INST_BYTE_OFFSET_LOG = 3;

  // instruction slot within a line
  localparam int OFFSET_BITS          = 3;
  localparam int INSTS_IN_LINE        = 8;

  // direct mapped, one line per index
  localparam int INDEX_BITS           = 4;
  localparam int NUM_LINES            = 16;

  // whatever is left of the pc above index and offset
  localparam int TAG_BITS             = 22;

  // instructions sit in the array as 40 bits, the pipeline wants 64
  localparam int STORED_INST_BITS     = 40;
  localparam int INST_BITS            = 64;
  localparam int LINE_BITS            = 320;

  // instructions handed to fetch per cycle
  localparam int FETCH_WIDTH          = 2;

  ////////////////////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [PC_BITS-1:0]     pc_t;
  typedef logic [OFFSET_BITS-1:0] offset_t;
  typedef logic [INDEX_BITS-1:0]  index_t;
  typedef logic [TAG_BITS-1:0]    tag_t;
  typedef logic [LINE_BITS-1:0]   line_t;
  typedef logic [INST_BITS-1:0]   inst_t;

  // memory request address, tag above index
  typedef logic [TAG_BITS+INDEX_BITS-1:0] block_addr_t;

endpackage
